// File: hw/cpu5stage.sv
module cpu5stage #(
	parameter int imem_words = 64,
	parameter int dmem_words = 64
) (
	input  logic                input_clk,
	input  logic                rst,
	input  logic                prog_we,
	input  logic [7:0]          prog_addr,
	input  cpu_isa_pkg::inst_t  prog_data,
	output logic [31:0]         pc,
	output logic [31:0]         cycles_consumed,
	output logic                commit_valid,
	output logic [4:0]          commit_rd,
	output logic [31:0]         commit_data,
	output logic                hlt
);

	cpu_pipe_pkg::if_id_t  if_id;
	cpu_pipe_pkg::id_ex_t  id_ex;
	cpu_pipe_pkg::ex_mem_t ex_mem;
	cpu_pipe_pkg::fwd_t    fwd_mem;
	cpu_pipe_pkg::fwd_t    fwd_wb;
	cpu_pipe_pkg::fwd_t    wb_write;
	logic                  stall;
	logic                  redirect;
	logic [31:0]           redirect_pc;

	always_ff @(posedge input_clk) begin
		if (rst)
			cycles_consumed <= '0;
		else if (!hlt)
			cycles_consumed <= cycles_consumed + 32'd1; // stops at halt
	end

	// ========================================================================
	// pipeline stages
	// ========================================================================

	fetch_stage #(.imem_words(imem_words)) i_fetch_stage (
		.input_clk(input_clk), .rst(rst), .stall(stall), .hlt(hlt),
		.redirect(redirect), .redirect_pc(redirect_pc),
		.prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
		.pc(pc), .if_id(if_id)
	);

	decode_stage i_decode_stage (
		.input_clk(input_clk), .rst(rst), .hlt(hlt), .redirect(redirect),
		.if_id(if_id), .wb_write(wb_write), .id_ex(id_ex), .stall(stall)
	);

	execute_stage i_execute_stage (
		.input_clk(input_clk), .rst(rst), .hlt(hlt), .id_ex(id_ex),
		.fwd_mem(fwd_mem), .fwd_wb(fwd_wb), .ex_mem(ex_mem),
		.redirect(redirect), .redirect_pc(redirect_pc)
	);

	memory_writeback #(.dmem_words(dmem_words)) i_memory_writeback (
		.input_clk(input_clk), .rst(rst), .ex_mem(ex_mem),
		.fwd_mem(fwd_mem), .fwd_wb(fwd_wb), .wb_write(wb_write),
		.commit_valid(commit_valid), .commit_rd(commit_rd), .commit_data(commit_data),
		.hlt(hlt)
	);

	// once halted the whole core stays frozen until reset
	a_halt_frozen: assert property (@(posedge input_clk) disable iff (rst)
		hlt |=> hlt && $stable(pc) && $stable(cycles_consumed) && !commit_valid);

endmodule

// File: hw/cpu_isa_pkg.sv
package cpu_isa_pkg;

	// ========================================================================
	// major opcodes and function codes
	// ========================================================================

	typedef enum logic [6:0] {
		op_reg    = 7'b0110011,
		op_imm    = 7'b0010011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_branch = 7'b1100011,
		op_system = 7'b1110011
	} op_t;

	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_slt     = 3'b010;
	localparam logic [2:0] f3_xor     = 3'b100;
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;
	localparam logic [2:0] f3_beq     = 3'b000;
	localparam logic [2:0] f3_bne     = 3'b001;
	localparam logic [6:0] f7_sub     = 7'b0100000;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt
	} alu_op_t;

	// ========================================================================
	// instruction word, one word seen through three formats
	// ========================================================================

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi; // also B format, bits reordered in decode
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
	} inst_t;

	localparam inst_t nop_word  = 32'h0000_0013; // addi x0, x0, 0
	localparam inst_t halt_word = 32'h0010_0073; // ebreak

endpackage

// File: hw/cpu_pipe_pkg.sv
package cpu_pipe_pkg;

	// ========================================================================
	// decoded control, carried down the pipe
	// ========================================================================

	typedef struct packed {
		logic                  regwrite;
		logic                  memread;
		logic                  memwrite;
		logic                  is_beq;
		logic                  is_bne;
		logic                  use_imm; // operand b from the immediate
		logic                  is_halt;
		cpu_isa_pkg::alu_op_t  alu_op;
	} ctrl_t;

	// ========================================================================
	// pipeline registers
	// ========================================================================

	typedef struct packed {
		logic               valid;
		logic [31:0]        pc;
		cpu_isa_pkg::inst_t inst;
	} if_id_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [31:0] rs1_val;
		logic [31:0] rs2_val;
		logic [31:0] imm;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  rd;
		ctrl_t       ctrl;
	} id_ex_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] alu_out; // also the data address
		logic [31:0] store_data;
		logic [4:0]  rd;
		ctrl_t       ctrl;
	} ex_mem_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] result;
		logic [4:0]  rd;
		logic        regwrite;
		logic        is_halt;
	} mem_wb_t;

	// one forwarding source, also the register file write port
	typedef struct packed {
		logic        we;
		logic [4:0]  rd;
		logic [31:0] value;
	} fwd_t;

endpackage

// File: hw/decode_stage.sv
module decode_stage (
	input  logic                  input_clk,
	input  logic                  rst,
	input  logic                  hlt,
	input  logic                  redirect,
	input  cpu_pipe_pkg::if_id_t  if_id,
	input  cpu_pipe_pkg::fwd_t    wb_write,
	output cpu_pipe_pkg::id_ex_t  id_ex,
	output logic                  stall
);

	cpu_isa_pkg::inst_t    inst;
	cpu_pipe_pkg::ctrl_t   ctrl;
	cpu_pipe_pkg::id_ex_t  nxt;
	logic [31:0]           imm;
	logic                  uses_rs1;
	logic                  uses_rs2;
	logic [31:0]           regs [1:31];

	assign inst = if_id.inst;

	function automatic cpu_isa_pkg::alu_op_t alu_sel(input logic [2:0] funct3, input logic sub);
		case (funct3)
			cpu_isa_pkg::f3_add_sub: return sub ? cpu_isa_pkg::alu_sub : cpu_isa_pkg::alu_add;
			cpu_isa_pkg::f3_slt:     return cpu_isa_pkg::alu_slt;
			cpu_isa_pkg::f3_xor:     return cpu_isa_pkg::alu_xor;
			cpu_isa_pkg::f3_or:      return cpu_isa_pkg::alu_or;
			cpu_isa_pkg::f3_and:     return cpu_isa_pkg::alu_and;
			default:                 return cpu_isa_pkg::alu_add;
		endcase
	endfunction

	// write-first, so a value retiring this cycle is seen here
	function automatic logic [31:0] read_port(input logic [4:0] idx);
		if (idx == 5'd0)
			return 32'd0;
		if (wb_write.we && wb_write.rd == idx)
			return wb_write.value;
		return regs[idx];
	endfunction

	// ========================================================================
	// decoder and immediates
	// ========================================================================

	always_comb begin
		ctrl     = '0;
		imm      = '0;
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		case (inst.r_fmt.opcode)
			cpu_isa_pkg::op_reg: begin
				ctrl.regwrite = 1'b1;
				ctrl.alu_op   = alu_sel(inst.r_fmt.funct3,
					inst.r_fmt.funct7 == cpu_isa_pkg::f7_sub);
				uses_rs1      = 1'b1;
				uses_rs2      = 1'b1;
			end
			cpu_isa_pkg::op_imm: begin
				ctrl.regwrite = 1'b1;
				ctrl.use_imm  = 1'b1;
				ctrl.alu_op   = alu_sel(inst.i_fmt.funct3, 1'b0);
				imm           = {{20{inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
				uses_rs1      = 1'b1;
			end
			cpu_isa_pkg::op_load: begin
				ctrl.regwrite = 1'b1;
				ctrl.memread  = 1'b1;
				ctrl.use_imm  = 1'b1;
				imm           = {{20{inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
				uses_rs1      = 1'b1;
			end
			cpu_isa_pkg::op_store: begin
				ctrl.memwrite = 1'b1;
				ctrl.use_imm  = 1'b1;
				imm           = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
				uses_rs1      = 1'b1;
				uses_rs2      = 1'b1;
			end
			cpu_isa_pkg::op_branch: begin
				ctrl.is_beq = inst.s_fmt.funct3 == cpu_isa_pkg::f3_beq;
				ctrl.is_bne = inst.s_fmt.funct3 == cpu_isa_pkg::f3_bne;
				imm         = {{19{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi[6],
					inst.s_fmt.imm_lo[0], inst.s_fmt.imm_hi[5:0], inst.s_fmt.imm_lo[4:1], 1'b0};
				uses_rs1    = 1'b1;
				uses_rs2    = 1'b1;
			end
			cpu_isa_pkg::op_system:
				ctrl.is_halt = inst == cpu_isa_pkg::halt_word;
			default: ;
		endcase
	end

	// ========================================================================
	// register file
	// ========================================================================

	always_ff @(posedge input_clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wb_write.we && wb_write.rd != 5'd0)
			regs[wb_write.rd] <= wb_write.value;
	end

	// load in EX feeding the instruction in ID
	assign stall = id_ex.valid && id_ex.ctrl.memread && id_ex.rd != 5'd0 && if_id.valid &&
		((uses_rs1 && inst.r_fmt.rs1 == id_ex.rd) || (uses_rs2 && inst.r_fmt.rs2 == id_ex.rd));

	always_comb begin
		nxt.valid   = if_id.valid && !stall && !redirect; // bubble on stall or flush
		nxt.pc      = if_id.pc;
		nxt.rs1_val = read_port(inst.r_fmt.rs1);
		nxt.rs2_val = read_port(inst.r_fmt.rs2);
		nxt.imm     = imm;
		nxt.rs1     = inst.r_fmt.rs1;
		nxt.rs2     = inst.r_fmt.rs2;
		nxt.rd      = inst.r_fmt.rd;
		nxt.ctrl    = nxt.valid ? ctrl : '0;
	end

	always_ff @(posedge input_clk) begin
		if (rst) begin
			id_ex.valid <= 1'b0;
			id_ex.ctrl  <= '0;
		end else if (!hlt)
			id_ex <= nxt;
	end

	// a branch in EX is never the load that causes a stall
	a_stall_redirect: assert property (@(posedge input_clk) disable iff (rst)
		!(stall && redirect));

endmodule

// File: hw/execute_stage.sv
module execute_stage (
	input  logic                   input_clk,
	input  logic                   rst,
	input  logic                   hlt,
	input  cpu_pipe_pkg::id_ex_t   id_ex,
	input  cpu_pipe_pkg::fwd_t     fwd_mem,
	input  cpu_pipe_pkg::fwd_t     fwd_wb,
	output cpu_pipe_pkg::ex_mem_t  ex_mem,
	output logic                   redirect,
	output logic [31:0]            redirect_pc
);

	logic [31:0] op_a;
	logic [31:0] rs2_fwd;
	logic [31:0] op_b;
	logic [31:0] alu_out;
	logic        equal;
	logic        taken;

	// MEM is younger than WB, so it wins
	function automatic logic [31:0] pick(input logic [4:0] idx, input logic [31:0] reg_val,
			input cpu_pipe_pkg::fwd_t m, input cpu_pipe_pkg::fwd_t w);
		if (idx != 5'd0 && m.we && m.rd == idx)
			return m.value;
		if (idx != 5'd0 && w.we && w.rd == idx)
			return w.value;
		return reg_val;
	endfunction

	// ========================================================================
	// operands and ALU
	// ========================================================================

	assign op_a    = pick(id_ex.rs1, id_ex.rs1_val, fwd_mem, fwd_wb);
	assign rs2_fwd = pick(id_ex.rs2, id_ex.rs2_val, fwd_mem, fwd_wb);
	assign op_b    = id_ex.ctrl.use_imm ? id_ex.imm : rs2_fwd;

	always_comb begin
		case (id_ex.ctrl.alu_op)
			cpu_isa_pkg::alu_add: alu_out = op_a + op_b;
			cpu_isa_pkg::alu_sub: alu_out = op_a - op_b;
			cpu_isa_pkg::alu_and: alu_out = op_a & op_b;
			cpu_isa_pkg::alu_or:  alu_out = op_a | op_b;
			cpu_isa_pkg::alu_xor: alu_out = op_a ^ op_b;
			cpu_isa_pkg::alu_slt: alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
			default:              alu_out = op_a + op_b;
		endcase
	end

	// ========================================================================
	// branch resolution
	// ========================================================================

	assign equal = op_a == rs2_fwd;
	assign taken = id_ex.valid &&
		((id_ex.ctrl.is_beq && equal) || (id_ex.ctrl.is_bne && !equal));
	assign redirect    = taken && !hlt; // frozen core does not redirect
	assign redirect_pc = id_ex.pc + id_ex.imm;

	always_ff @(posedge input_clk) begin
		if (rst) begin
			ex_mem.valid <= 1'b0;
			ex_mem.ctrl  <= '0;
		end else if (!hlt) begin
			ex_mem.valid      <= id_ex.valid;
			ex_mem.alu_out    <= alu_out;
			ex_mem.store_data <= rs2_fwd;
			ex_mem.rd         <= id_ex.rd;
			ex_mem.ctrl       <= id_ex.ctrl;
		end
	end

	// the flush turns the next EX entry into a bubble
	a_redirect_branch: assert property (@(posedge input_clk) disable iff (rst)
		redirect |-> (id_ex.valid && (id_ex.ctrl.is_beq || id_ex.ctrl.is_bne)) ##1 !redirect);

endmodule

// File: hw/fetch_stage.sv
module fetch_stage #(
	parameter int imem_words = 64
) (
	input  logic                  input_clk,
	input  logic                  rst,
	input  logic                  stall,
	input  logic                  hlt,
	input  logic                  redirect,
	input  logic [31:0]           redirect_pc,
	input  logic                  prog_we,
	input  logic [7:0]            prog_addr,
	input  cpu_isa_pkg::inst_t    prog_data,
	output logic [31:0]           pc,
	output cpu_pipe_pkg::if_id_t  if_id
);

	localparam int aw = $clog2(imem_words);

	cpu_isa_pkg::inst_t imem [imem_words];
	cpu_isa_pkg::inst_t fetched;

	// ========================================================================
	// instruction memory, loaded from the program port
	// ========================================================================

	always_ff @(posedge input_clk) begin
		if (prog_we)
			imem[prog_addr[aw-1:0]] <= prog_data;
	end

	assign fetched = imem[pc[aw+1:2]]; // word addressed

	// ========================================================================
	// program counter and IF/ID
	// ========================================================================

	always_ff @(posedge input_clk) begin
		if (rst)
			pc <= '0;
		else if (!hlt) begin
			if (redirect)
				pc <= redirect_pc; // taken branch
			else if (!stall)
				pc <= pc + 32'd4;
		end
	end

	always_ff @(posedge input_clk) begin
		if (rst) begin
			if_id.valid <= 1'b0;
			if_id.inst  <= cpu_isa_pkg::nop_word;
		end else if (!hlt) begin
			if (redirect) begin
				if_id.valid <= 1'b0; // squash wrong path
				if_id.inst  <= cpu_isa_pkg::nop_word;
			end else if (!stall) begin
				if_id.valid <= 1'b1;
				if_id.pc    <= pc;
				if_id.inst  <= fetched;
			end
		end
	end

endmodule

// File: hw/memory_writeback.sv
module memory_writeback #(
	parameter int dmem_words = 64
) (
	input  logic                   input_clk,
	input  logic                   rst,
	input  cpu_pipe_pkg::ex_mem_t  ex_mem,
	output cpu_pipe_pkg::fwd_t     fwd_mem,
	output cpu_pipe_pkg::fwd_t     fwd_wb,
	output cpu_pipe_pkg::fwd_t     wb_write,
	output logic                   commit_valid,
	output logic [4:0]             commit_rd,
	output logic [31:0]            commit_data,
	output logic                   hlt
);

	localparam int aw = $clog2(dmem_words);

	logic [31:0]           dmem [dmem_words];
	logic [aw-1:0]         idx;
	logic [31:0]           result;
	cpu_pipe_pkg::mem_wb_t mem_wb;

	// ========================================================================
	// data memory
	// ========================================================================

	assign idx    = ex_mem.alu_out[aw+1:2];
	assign result = ex_mem.ctrl.memread ? dmem[idx] : ex_mem.alu_out;

	always_ff @(posedge input_clk) begin
		if (ex_mem.valid && ex_mem.ctrl.memwrite && !hlt)
			dmem[idx] <= ex_mem.store_data;
	end

	// ========================================================================
	// MEM/WB, commit and halt
	// ========================================================================

	always_ff @(posedge input_clk) begin
		if (rst) begin
			mem_wb.valid    <= 1'b0;
			mem_wb.regwrite <= 1'b0;
			mem_wb.is_halt  <= 1'b0;
		end else if (!hlt) begin
			mem_wb.valid    <= ex_mem.valid;
			mem_wb.result   <= result;
			mem_wb.rd       <= ex_mem.rd;
			mem_wb.regwrite <= ex_mem.ctrl.regwrite;
			mem_wb.is_halt  <= ex_mem.ctrl.is_halt;
		end
	end

	assign fwd_mem = '{we: ex_mem.valid && ex_mem.ctrl.regwrite, rd: ex_mem.rd, value: result};
	assign fwd_wb  = '{we: mem_wb.valid && mem_wb.regwrite, rd: mem_wb.rd, value: mem_wb.result};
	assign wb_write = '{we: fwd_wb.we && mem_wb.rd != 5'd0, rd: mem_wb.rd, value: mem_wb.result};

	assign commit_valid = wb_write.we;
	assign commit_rd    = mem_wb.rd;
	assign commit_data  = mem_wb.result;
	assign hlt          = mem_wb.valid && mem_wb.is_halt; // held, so it stays high

	a_dmem_range: assert property (@(posedge input_clk) disable iff (rst)
		ex_mem.valid && (ex_mem.ctrl.memread || ex_mem.ctrl.memwrite)
		|-> ex_mem.alu_out[31:2] < dmem_words);

endmodule

// File: tb.f
hw/cpu_isa_pkg.sv
hw/cpu_pipe_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_writeback.sv
hw/cpu5stage.sv
test/tb_cpu5stage.sv

// File: test/tb_cpu5stage.sv
module tb_cpu5stage;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int imem_words   = 64;
	localparam int dmem_words   = 64;
	localparam int num_programs = 20;
	localparam int max_len      = 41;
	localparam int halt_pad     = 7; // halts loaded behind each program
	localparam int reset_cycles = 3;
	localparam int data_words   = 4; // words touched by lw and sw
	// load, reset, worst case run with stalls, halt checks
	localparam int timeout_cycles =
		num_programs * (max_len + halt_pad + reset_cycles + 4 * max_len + 20 + 10);

	localparam logic [31:0] halt_enc = 32'h0010_0073; // ebreak

	localparam int k_alu  = 0;
	localparam int k_addi = 1;
	localparam int k_lw   = 2;
	localparam int k_sw   = 3;
	localparam int k_br   = 4;
	localparam int k_halt = 5;

	logic        input_clk = 1'b0;
	logic        rst;
	logic        prog_we;
	logic [7:0]  prog_addr;
	logic [31:0] prog_data;
	logic [31:0] pc;
	logic [31:0] cycles_consumed;
	logic        commit_valid;
	logic [4:0]  commit_rd;
	logic [31:0] commit_data;
	logic        hlt;

	logic [31:0] rng_state;
	int          cycle_count = 0;
	int          run_cycles;
	string       cur_test;
	int          prog_len;
	int          ins_kind [imem_words];
	int          ins_func [imem_words]; // alu op, or 0 beq and 1 bne
	int          ins_rd [imem_words];
	int          ins_rs1 [imem_words];
	int          ins_rs2 [imem_words];
	int          ins_imm [imem_words];
	logic [4:0]  exp_rd [$];
	logic [31:0] exp_val [$];

	cpu5stage #(.imem_words(imem_words), .dmem_words(dmem_words)) i_cpu5stage (
		.input_clk(input_clk), .rst(rst), .prog_we(prog_we), .prog_addr(prog_addr),
		.prog_data(prog_data), .pc(pc), .cycles_consumed(cycles_consumed),
		.commit_valid(commit_valid), .commit_rd(commit_rd), .commit_data(commit_data),
		.hlt(hlt)
	);

	always #4 input_clk = ~input_clk;

	task automatic stop_on_error();
		$display("Done: errors found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("FAIL %s expected 0x%08h actual 0x%08h", name, expected, actual);
		stop_on_error();
	endtask

	task automatic report_error(input string what);
		$display("ERROR %s: %s", cur_test, what);
		stop_on_error();
	endtask

	// ========================================================================
	// random program generation
	// ========================================================================

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = next_rand();
		return int'(r % n);
	endfunction

	task automatic gen_program();
		int r;
		int prev_rd;
		prev_rd = 0;
		prog_len = 20 + rand_below(21);
		for (int i = 0; i < prog_len; i++) begin
			r = rand_below(100);
			ins_rd[i]   = rand_below(8);
			ins_rs1[i]  = (rand_below(2) == 0) ? prev_rd : rand_below(8); // dense deps
			ins_rs2[i]  = rand_below(8);
			ins_func[i] = 0;
			ins_imm[i]  = 0;
			if (i < data_words) begin
				ins_kind[i] = k_sw; // clear the data words first
				ins_rs2[i]  = 0;
				r           = -1;
			end else if (r < 30) begin
				ins_kind[i] = k_alu;
				ins_func[i] = rand_below(6);
			end else if (r < 55) begin
				ins_kind[i] = k_addi;
				ins_imm[i]  = rand_below(4096) - 2048;
			end else if (r < 70) begin
				ins_kind[i] = k_lw;
			end else if (r < 85) begin
				ins_kind[i] = k_sw;
			end else if (i + 2 <= prog_len) begin
				ins_kind[i] = k_br;
				ins_func[i] = rand_below(2);
				ins_imm[i]  = 4 * ((i + 4 <= prog_len) ? 2 + rand_below(3) : prog_len - i);
			end else begin
				ins_kind[i] = k_addi;
				ins_imm[i]  = rand_below(64);
			end
			if (ins_kind[i] == k_lw || ins_kind[i] == k_sw) begin
				ins_rs1[i] = 0; // x0 base
				if (r >= 0)
					ins_imm[i] = 4 * rand_below(data_words);
				else
					ins_imm[i] = 4 * i;
			end
			if (ins_kind[i] == k_alu || ins_kind[i] == k_addi || ins_kind[i] == k_lw)
				prev_rd = ins_rd[i];
		end
		ins_kind[prog_len] = k_halt;
	endtask

	function automatic logic [31:0] encode(input int i);
		logic [31:0] iv;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic [6:0]  f7;
		iv  = ins_imm[i];
		rd  = 5'(ins_rd[i]);
		rs1 = 5'(ins_rs1[i]);
		rs2 = 5'(ins_rs2[i]);
		f7  = 7'd0;
		case (ins_func[i])
			0:       f3 = 3'b000;
			1: begin
				f3 = 3'b000;
				f7 = 7'b0100000; // sub
			end
			2:       f3 = 3'b111;
			3:       f3 = 3'b110;
			4:       f3 = 3'b100;
			default: f3 = 3'b010;
		endcase
		case (ins_kind[i])
			k_alu:  return {f7, rs2, rs1, f3, rd, 7'b0110011};
			k_addi: return {iv[11:0], rs1, 3'b000, rd, 7'b0010011};
			k_lw:   return {iv[11:0], 5'd0, 3'b010, rd, 7'b0000011};
			k_sw:   return {iv[11:5], rs2, 5'd0, 3'b010, iv[4:0], 7'b0100011};
			k_br:   return {iv[12], iv[10:5], rs2, rs1, (ins_func[i] == 0) ? 3'b000 : 3'b001,
				iv[4:1], iv[11], 7'b1100011};
			default: return halt_enc;
		endcase
	endfunction

	// ========================================================================
	// ISA model that fills the expected commit queue
	// ========================================================================

	task automatic run_model();
		logic [31:0] x [32];
		logic [31:0] mem [data_words];
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] v;
		logic        wr;
		int          i;
		for (int r = 0; r < 32; r++)
			x[r] = '0;
		exp_rd.delete();
		exp_val.delete();
		i = 0;
		while (ins_kind[i] != k_halt) begin
			a  = x[ins_rs1[i]];
			b  = x[ins_rs2[i]];
			wr = 1'b0;
			v  = '0;
			case (ins_kind[i])
				k_alu: begin
					wr = 1'b1;
					case (ins_func[i])
						0:       v = a + b;
						1:       v = a - b;
						2:       v = a & b;
						3:       v = a | b;
						4:       v = a ^ b;
						default: v = {31'd0, $signed(a) < $signed(b)};
					endcase
				end
				k_addi: begin
					wr = 1'b1;
					v  = a + ins_imm[i];
				end
				k_lw: begin
					wr = 1'b1;
					v  = mem[ins_imm[i] / 4];
				end
				k_sw: mem[ins_imm[i] / 4] = b;
				default: ;
			endcase
			if (wr && ins_rd[i] != 0) begin // x0 stays zero and never commits
				x[ins_rd[i]] = v;
				exp_rd.push_back(5'(ins_rd[i]));
				exp_val.push_back(v);
			end
			if (ins_kind[i] == k_br && ((ins_func[i] == 0) == (a == b)))
				i = i + ins_imm[i] / 4; // taken
			else
				i = i + 1;
		end
	endtask

	// ========================================================================
	// program load, reset, halt checks
	// ========================================================================

	task automatic load_and_reset();
		@(posedge input_clk);
		#1;
		rst = 1'b1;
		for (int i = 0; i <= prog_len + halt_pad; i++) begin
			prog_we   = 1'b1;
			prog_addr = 8'(i);
			prog_data = (i < prog_len) ? encode(i) : halt_enc;
			@(posedge input_clk);
			#1;
		end
		prog_we = 1'b0;
		repeat (reset_cycles) begin
			@(posedge input_clk);
			#1;
		end
		assert (pc == 32'd0) else report_mismatch({cur_test, " reset pc"}, 0, pc);
		assert (!commit_valid) else report_error("commit_valid high in reset");
		assert (!hlt) else report_error("hlt high in reset");
		assert (cycles_consumed == 32'd0)
			else report_mismatch({cur_test, " reset cycles"}, 0, cycles_consumed);
		rst = 1'b0;
	endtask

	task automatic check_halted();
		logic [31:0] pc_hold;
		logic [31:0] cyc_hold;
		pc_hold  = pc;
		cyc_hold = cycles_consumed;
		assert (exp_rd.size() == 0)
			else report_mismatch({cur_test, " pending commits"}, 0, exp_rd.size());
		repeat (10) begin
			@(negedge input_clk);
			assert (hlt) else report_error("hlt dropped after halt");
			assert (pc == pc_hold) else report_mismatch({cur_test, " halted pc"}, pc_hold, pc);
			assert (cycles_consumed == cyc_hold)
				else report_mismatch({cur_test, " halted cycles"}, cyc_hold, cycles_consumed);
		end
	endtask

	// commits are compared in program order
	always @(negedge input_clk) begin
		if (!rst && commit_valid) begin
			assert (commit_rd != 5'd0) else report_error("commit to x0");
			assert (exp_rd.size() > 0) else report_error("commit with nothing expected");
			assert (commit_rd == exp_rd[0])
				else report_mismatch({cur_test, " commit_rd"}, exp_rd[0], commit_rd);
			assert (commit_data == exp_val[0])
				else report_mismatch({cur_test, " commit_data"}, exp_val[0], commit_data);
			void'(exp_rd.pop_front());
			void'(exp_val.pop_front());
		end
	end

	always @(posedge input_clk) begin
		cycle_count++;
		if (cycle_count > timeout_cycles)
			report_error("timeout, the core never reached halt");
	end

	initial begin
		rst       = 1'b1;
		prog_we   = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		rng_state = 32'hff86;
		for (int p = 0; p < num_programs; p++) begin
			cur_test = $sformatf("prog%0d", p);
			gen_program();
			run_model();
			load_and_reset();
			@(negedge input_clk);
			run_cycles = 0;
			while (!hlt) begin
				@(negedge input_clk);
				run_cycles++; // edges since reset, up to the one that raised hlt
			end
			assert (cycles_consumed == 32'(run_cycles))
				else report_mismatch({cur_test, " cycles_consumed"}, run_cycles,
					cycles_consumed);
			check_halted();
		end
		$display("Done: no errors");
		$finish;
	end

endmodule
